//--- src/ex_pkg.sv
package ex_pkg;

    localparam int unsigned xlen = 32;
    localparam int unsigned op_w = 5;

    // alu group
    localparam logic [op_w-1:0] op_add     = 5'd0;
    localparam logic [op_w-1:0] op_sub     = 5'd1;
    localparam logic [op_w-1:0] op_slt     = 5'd2;
    localparam logic [op_w-1:0] op_sltu    = 5'd3;
    localparam logic [op_w-1:0] op_and     = 5'd4;
    localparam logic [op_w-1:0] op_or      = 5'd5;
    localparam logic [op_w-1:0] op_nor     = 5'd6;
    localparam logic [op_w-1:0] op_xor     = 5'd7;
    localparam logic [op_w-1:0] op_sll     = 5'd8;
    localparam logic [op_w-1:0] op_srl     = 5'd9;
    localparam logic [op_w-1:0] op_sra     = 5'd10;
    localparam logic [op_w-1:0] op_lui     = 5'd11;

    // multiply
    localparam logic [op_w-1:0] op_mul     = 5'd12;
    localparam logic [op_w-1:0] op_mulh    = 5'd13;
    localparam logic [op_w-1:0] op_mulhu   = 5'd14;

    // divide
    localparam logic [op_w-1:0] op_div     = 5'd15;
    localparam logic [op_w-1:0] op_mod     = 5'd16;
    localparam logic [op_w-1:0] op_divu    = 5'd17;
    localparam logic [op_w-1:0] op_modu    = 5'd18;

    // stable counter reads
    localparam logic [op_w-1:0] op_rdcntvl = 5'd19;
    localparam logic [op_w-1:0] op_rdcntvh = 5'd20;

    // access size for the alignment check
    localparam logic [1:0] msz_none = 2'd0;
    localparam logic [1:0] msz_byte = 2'd1;
    localparam logic [1:0] msz_half = 2'd2;
    localparam logic [1:0] msz_word = 2'd3;

    localparam int unsigned div_bits_per_step = 4;
    localparam int unsigned div_steps         = xlen / div_bits_per_step;
    // one register per step plus the post register
    localparam int unsigned div_latency       = div_steps + 1;

endpackage

//--- src/ex_alu.sv
`timescale 1ns/1ps

module ex_alu (
    input  logic [ex_pkg::op_w-1:0] op,
    input  logic [ex_pkg::xlen-1:0] src1,
    input  logic [ex_pkg::xlen-1:0] src2,
    output logic [ex_pkg::xlen-1:0] result
);

    logic [4:0]              shamt;
    logic [ex_pkg::xlen-1:0] sum;
    logic [ex_pkg::xlen-1:0] diff;

    assign shamt = src2[4:0];
    assign sum   = src1 + src2;
    assign diff  = src1 - src2;

    always_comb begin
        case (op)
            ex_pkg::op_add: begin
                result = sum;
            end
            ex_pkg::op_sub: begin
                result = diff;
            end
            ex_pkg::op_slt: begin
                result = {31'b0, $signed(src1) < $signed(src2)};
            end
            ex_pkg::op_sltu: begin
                result = {31'b0, src1 < src2};
            end
            ex_pkg::op_and: begin
                result = src1 & src2;
            end
            ex_pkg::op_or: begin
                result = src1 | src2;
            end
            ex_pkg::op_nor: begin
                result = ~(src1 | src2);
            end
            ex_pkg::op_xor: begin
                result = src1 ^ src2;
            end
            ex_pkg::op_sll: begin
                result = src1 << shamt;
            end
            ex_pkg::op_srl: begin
                result = src1 >> shamt;
            end
            ex_pkg::op_sra: begin
                result = $unsigned($signed(src1) >>> shamt);
            end
            ex_pkg::op_lui: begin
                // decode already placed the immediate in the upper bits
                result = src2;
            end
            default: begin
                // loads and stores use this as the address sum
                result = sum;
            end
        endcase
    end

endmodule

//--- src/ex_div_prep.sv
`timescale 1ns/1ps

module ex_div_prep (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  logic                    start,
    input  logic                    is_signed,
    input  logic [ex_pkg::xlen-1:0] dividend,
    input  logic [ex_pkg::xlen-1:0] divisor,
    output logic                    out_valid,
    output logic [ex_pkg::xlen-1:0] rem_init,
    output logic [ex_pkg::xlen-1:0] quo_init,
    output logic [ex_pkg::xlen-1:0] dvs,
    output logic                    neg_q,
    output logic                    neg_r,
    output logic                    by_zero,
    output logic [ex_pkg::xlen-1:0] orig_dividend
);

    logic                    dnd_neg;
    logic                    dvs_neg;
    logic [ex_pkg::xlen-1:0] dnd_mag;
    logic [ex_pkg::xlen-1:0] dvs_mag;

    assign dnd_neg = is_signed & dividend[ex_pkg::xlen-1];
    assign dvs_neg = is_signed & divisor[ex_pkg::xlen-1];
    // 0x80000000 keeps its bit pattern, which is its unsigned magnitude
    assign dnd_mag = dnd_neg ? -dividend : dividend;
    assign dvs_mag = dvs_neg ? -divisor : divisor;

    always_ff @(posedge clk) begin
        if (rst | flush) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rem_init      <= '0;
            quo_init      <= dnd_mag;
            dvs           <= dvs_mag;
            neg_q         <= dnd_neg ^ dvs_neg;
            neg_r         <= dnd_neg;
            by_zero       <= (divisor == '0);
            orig_dividend <= dividend;
        end
    end

endmodule

//--- src/ex_div_step.sv
`timescale 1ns/1ps

module ex_div_step (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  logic                    in_valid,
    input  logic [ex_pkg::xlen-1:0] in_rem,
    input  logic [ex_pkg::xlen-1:0] in_quo,
    input  logic [ex_pkg::xlen-1:0] in_dvs,
    input  logic                    in_neg_q,
    input  logic                    in_neg_r,
    input  logic                    in_by_zero,
    input  logic [ex_pkg::xlen-1:0] in_orig,
    output logic                    out_valid,
    output logic [ex_pkg::xlen-1:0] out_rem,
    output logic [ex_pkg::xlen-1:0] out_quo,
    output logic [ex_pkg::xlen-1:0] out_dvs,
    output logic                    out_neg_q,
    output logic                    out_neg_r,
    output logic                    out_by_zero,
    output logic [ex_pkg::xlen-1:0] out_orig
);

    logic [ex_pkg::xlen-1:0] rem_c;
    logic [ex_pkg::xlen-1:0] quo_c;
    logic [ex_pkg::xlen:0]   shifted;
    logic [ex_pkg::xlen:0]   trial;

    // quo shifts dividend bits out at the top and quotient bits in at the bottom
    always_comb begin
        rem_c   = in_rem;
        quo_c   = in_quo;
        shifted = '0;
        trial   = '0;
        for (int i = 0; i < ex_pkg::div_bits_per_step; i++) begin
            shifted = {rem_c, quo_c[ex_pkg::xlen-1]};
            trial   = shifted - {1'b0, in_dvs};
            if (!trial[ex_pkg::xlen]) begin
                rem_c = trial[ex_pkg::xlen-1:0];
                quo_c = {quo_c[ex_pkg::xlen-2:0], 1'b1};
            end else begin
                rem_c = shifted[ex_pkg::xlen-1:0];
                quo_c = {quo_c[ex_pkg::xlen-2:0], 1'b0};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst | flush) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_rem     <= rem_c;
            out_quo     <= quo_c;
            out_dvs     <= in_dvs;
            out_neg_q   <= in_neg_q;
            out_neg_r   <= in_neg_r;
            out_by_zero <= in_by_zero;
            out_orig    <= in_orig;
        end
    end

endmodule

//--- src/ex_div_post.sv
`timescale 1ns/1ps

module ex_div_post (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  logic                    in_valid,
    input  logic [ex_pkg::xlen-1:0] in_rem,
    input  logic [ex_pkg::xlen-1:0] in_quo,
    input  logic                    in_neg_q,
    input  logic                    in_neg_r,
    input  logic                    in_by_zero,
    input  logic [ex_pkg::xlen-1:0] in_orig,
    output logic                    res_valid,
    output logic [ex_pkg::xlen-1:0] quotient,
    output logic [ex_pkg::xlen-1:0] remainder
);

    logic [ex_pkg::xlen-1:0] quo_fix;
    logic [ex_pkg::xlen-1:0] rem_fix;

    // divide by zero gives all ones and the untouched dividend in every form
    assign quo_fix = in_by_zero ? '1 : (in_neg_q ? -in_quo : in_quo);
    assign rem_fix = in_by_zero ? in_orig : (in_neg_r ? -in_rem : in_rem);

    always_ff @(posedge clk) begin
        if (rst | flush) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            quotient  <= quo_fix;
            remainder <= rem_fix;
        end
    end

endmodule

//--- src/ex_stage.sv
`timescale 1ns/1ps

module ex_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  logic                    in_valid,
    input  logic [ex_pkg::xlen-1:0] in_pc,
    input  logic [ex_pkg::op_w-1:0] in_op,
    input  logic [ex_pkg::xlen-1:0] in_src1,
    input  logic [ex_pkg::xlen-1:0] in_src2,
    input  logic [1:0]              in_mem_size,
    input  logic                    in_gr_we,
    input  logic                    in_res_from_mem,
    input  logic                    in_mem_we,
    input  logic [4:0]              in_waddr,
    input  logic [63:0]             counter,
    input  logic                    mem_allowin,
    output logic                    allowin,
    output logic                    out_valid,
    output logic [ex_pkg::xlen-1:0] out_pc,
    output logic [ex_pkg::xlen-1:0] out_result,
    output logic [4:0]              out_waddr,
    output logic                    out_gr_we,
    output logic                    out_res_from_mem,
    output logic                    out_mem_we,
    output logic                    out_ale,
    output logic                    fwd_valid,
    output logic [4:0]              fwd_addr,
    output logic [ex_pkg::xlen-1:0] fwd_data,
    output logic                    ex_is_load
);

    localparam int unsigned xw = ex_pkg::xlen;
    localparam int unsigned ns = ex_pkg::div_steps;

    logic            held;
    logic            launched;
    logic            waiting;
    logic            readygo;
    logic            accept;
    logic            first_cycle;
    logic            is_div;
    logic            div_start;

    logic [ex_pkg::op_w-1:0] op_q;
    logic [xw-1:0]           pc_q;
    logic [xw-1:0]           src1_q;
    logic [xw-1:0]           src2_q;
    logic [1:0]              msz_q;
    logic                    gr_we_q;
    logic                    res_from_mem_q;
    logic                    mem_we_q;
    logic [4:0]              waddr_q;
    logic [xw-1:0]           cnt_q;

    logic [xw-1:0]   alu_result;
    logic [xw:0]     mul_a;
    logic [xw:0]     mul_b;
    logic [2*xw+1:0] prod_q;
    logic [xw-1:0]   div_res_q;
    logic [xw-1:0]   result;

    // index k of the divider chain feeds step k
    logic            st_valid   [ns+1];
    logic [xw-1:0]   st_rem     [ns+1];
    logic [xw-1:0]   st_quo     [ns+1];
    logic [xw-1:0]   st_dvs     [ns+1];
    logic            st_neg_q   [ns+1];
    logic            st_neg_r   [ns+1];
    logic            st_by_zero [ns+1];
    logic [xw-1:0]   st_orig    [ns+1];
    logic            div_res_valid;
    logic [xw-1:0]   div_quo;
    logic [xw-1:0]   div_rem;

    assign out_valid   = readygo & mem_allowin;
    assign allowin     = ~held | out_valid;
    assign accept      = in_valid & allowin;
    assign first_cycle = held & ~launched;
    assign is_div      = op_q inside {ex_pkg::op_div, ex_pkg::op_mod,
                                      ex_pkg::op_divu, ex_pkg::op_modu};
    assign div_start   = first_cycle & is_div;

    always_ff @(posedge clk) begin
        if (rst | flush) begin
            held <= 1'b0;
        end else if (accept) begin
            held <= 1'b1;
        end else if (out_valid) begin
            held <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst | flush | accept) begin
            launched <= 1'b0;
        end else if (first_cycle) begin
            launched <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst | flush) begin
            waiting <= 1'b0;
        end else if (div_start) begin
            waiting <= 1'b1;
        end else if (div_res_valid) begin
            waiting <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst | flush) begin
            readygo <= 1'b0;
        end else if ((first_cycle & ~is_div) | (waiting & div_res_valid)) begin
            readygo <= 1'b1;
        end else if (out_valid) begin
            readygo <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q           <= in_op;
            pc_q           <= in_pc;
            src1_q         <= in_src1;
            src2_q         <= in_src2;
            msz_q          <= in_mem_size;
            gr_we_q        <= in_gr_we;
            res_from_mem_q <= in_res_from_mem;
            mem_we_q       <= in_mem_we;
            waddr_q        <= in_waddr;
            // counter value as seen at acceptance
            cnt_q          <= (in_op == ex_pkg::op_rdcntvh) ? counter[63:32] : counter[31:0];
        end
    end

    ex_alu u_alu (
        .op     (op_q),
        .src1   (src1_q),
        .src2   (src2_q),
        .result (alu_result)
    );

    // 33-bit operands cover signed, unsigned and mixed forms
    assign mul_a = {(op_q != ex_pkg::op_mulhu) & src1_q[xw-1], src1_q};
    assign mul_b = {(op_q != ex_pkg::op_mulhu) & src2_q[xw-1], src2_q};

    always_ff @(posedge clk) begin
        if (first_cycle) begin
            prod_q <= $signed(mul_a) * $signed(mul_b);
        end
    end

    ex_div_prep u_div_prep (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .start         (div_start),
        .is_signed     ((op_q == ex_pkg::op_div) | (op_q == ex_pkg::op_mod)),
        .dividend      (src1_q),
        .divisor       (src2_q),
        .out_valid     (st_valid[0]),
        .rem_init      (st_rem[0]),
        .quo_init      (st_quo[0]),
        .dvs           (st_dvs[0]),
        .neg_q         (st_neg_q[0]),
        .neg_r         (st_neg_r[0]),
        .by_zero       (st_by_zero[0]),
        .orig_dividend (st_orig[0])
    );

    for (genvar k = 0; k < ns; k++) begin : g_step
        ex_div_step u_step (
            .clk         (clk),
            .rst         (rst),
            .flush       (flush),
            .in_valid    (st_valid[k]),
            .in_rem      (st_rem[k]),
            .in_quo      (st_quo[k]),
            .in_dvs      (st_dvs[k]),
            .in_neg_q    (st_neg_q[k]),
            .in_neg_r    (st_neg_r[k]),
            .in_by_zero  (st_by_zero[k]),
            .in_orig     (st_orig[k]),
            .out_valid   (st_valid[k+1]),
            .out_rem     (st_rem[k+1]),
            .out_quo     (st_quo[k+1]),
            .out_dvs     (st_dvs[k+1]),
            .out_neg_q   (st_neg_q[k+1]),
            .out_neg_r   (st_neg_r[k+1]),
            .out_by_zero (st_by_zero[k+1]),
            .out_orig    (st_orig[k+1])
        );
    end

    ex_div_post u_div_post (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .in_valid   (st_valid[ns]),
        .in_rem     (st_rem[ns]),
        .in_quo     (st_quo[ns]),
        .in_neg_q   (st_neg_q[ns]),
        .in_neg_r   (st_neg_r[ns]),
        .in_by_zero (st_by_zero[ns]),
        .in_orig    (st_orig[ns]),
        .res_valid  (div_res_valid),
        .quotient   (div_quo),
        .remainder  (div_rem)
    );

    always_ff @(posedge clk) begin
        if (waiting & div_res_valid) begin
            if ((op_q == ex_pkg::op_div) | (op_q == ex_pkg::op_divu)) begin
                div_res_q <= div_quo;
            end else begin
                div_res_q <= div_rem;
            end
        end
    end

    always_comb begin
        case (op_q)
            ex_pkg::op_mul: begin
                result = prod_q[xw-1:0];
            end
            ex_pkg::op_mulh, ex_pkg::op_mulhu: begin
                result = prod_q[2*xw-1:xw];
            end
            ex_pkg::op_div, ex_pkg::op_mod, ex_pkg::op_divu, ex_pkg::op_modu: begin
                result = div_res_q;
            end
            ex_pkg::op_rdcntvl, ex_pkg::op_rdcntvh: begin
                result = cnt_q;
            end
            default: begin
                result = alu_result;
            end
        endcase
    end

    assign out_pc           = pc_q;
    assign out_result       = result;
    assign out_waddr        = waddr_q;
    assign out_gr_we        = gr_we_q;
    assign out_res_from_mem = res_from_mem_q;
    assign out_mem_we       = mem_we_q;
    assign out_ale = ((msz_q == ex_pkg::msz_word) & (|alu_result[1:0]))
                   | ((msz_q == ex_pkg::msz_half) & alu_result[0]);

    // loads resolve in memory, so decode stalls on ex_is_load instead
    assign fwd_valid  = held & gr_we_q & ~res_from_mem_q;
    assign fwd_addr   = waddr_q;
    assign fwd_data   = result;
    assign ex_is_load = held & res_from_mem_q;

endmodule

//--- sim/ex_stage_assert.sv
`timescale 1ns/1ps

module ex_stage_assert (
    input logic        clk,
    input logic        rst,
    input logic        flush,
    input logic        mem_allowin,
    input logic        allowin,
    input logic        out_valid,
    input logic        held,
    input logic        readygo,
    input logic        waiting,
    input logic [31:0] out_pc,
    input logic [31:0] out_result,
    input logic [4:0]  out_waddr,
    input logic        out_ale
);

    int unsigned fail_count = 0;

    a_stall_blocks_allowin: assert property (@(posedge clk) disable iff (rst)
        held && !mem_allowin |-> !allowin)
    else begin
        fail_count++;
        $error("allowin high while the stage is held and memory stalls");
    end

    a_no_transfer_on_stall: assert property (@(posedge clk) disable iff (rst)
        !mem_allowin |-> !out_valid)
    else begin
        fail_count++;
        $error("out_valid high while mem_allowin is low");
    end

    // finished instruction waits unchanged for memory
    a_stall_keeps_outputs: assert property (@(posedge clk) disable iff (rst)
        readygo && !mem_allowin && !flush |=> readygo && $stable(out_pc)
            && $stable(out_result) && $stable(out_waddr) && $stable(out_ale))
    else begin
        fail_count++;
        $error("outputs changed while stalled");
    end

    a_divide_needs_held: assert property (@(posedge clk) disable iff (rst)
        waiting |-> held)
    else begin
        fail_count++;
        $error("divide in flight with an empty stage");
    end

endmodule

//--- sim/ex_stage_tb.sv
`timescale 1ns/1ps

module ex_stage_tb;

    localparam int max_cases   = 64;
    localparam int send_limit  = 100;
    localparam int drain_limit = 200;
    localparam int flush_delay = 4;

    logic                    clk;
    logic                    rst;
    logic                    flush;
    logic                    in_valid;
    logic [31:0]             in_pc;
    logic [ex_pkg::op_w-1:0] in_op;
    logic [31:0]             in_src1;
    logic [31:0]             in_src2;
    logic [1:0]              in_mem_size;
    logic                    in_gr_we;
    logic                    in_res_from_mem;
    logic                    in_mem_we;
    logic [4:0]              in_waddr;
    logic [63:0]             counter;
    logic                    mem_allowin;
    logic                    allowin;
    logic                    out_valid;
    logic [31:0]             out_pc;
    logic [31:0]             out_result;
    logic [4:0]              out_waddr;
    logic                    out_gr_we;
    logic                    out_res_from_mem;
    logic                    out_mem_we;
    logic                    out_ale;
    logic                    fwd_valid;
    logic [4:0]              fwd_addr;
    logic [31:0]             fwd_data;
    logic                    ex_is_load;

    // one entry per line of the case file
    logic                    c_flush  [max_cases];
    logic [ex_pkg::op_w-1:0] c_op     [max_cases];
    logic [31:0]             c_src1   [max_cases];
    logic [31:0]             c_src2   [max_cases];
    logic [1:0]              c_msz    [max_cases];
    logic                    c_we     [max_cases];
    logic                    c_ld     [max_cases];
    logic                    c_st     [max_cases];
    logic [4:0]              c_waddr  [max_cases];
    logic [31:0]             c_result [max_cases];
    logic                    c_ale    [max_cases];
    logic [31:0]             c_cnt    [max_cases];

    int     n_cases;
    int     pend[$];
    int     checks;
    int     errors;
    int     n_out;
    int     n_expect;
    logic   timed_out;
    integer seed;

    ex_stage u_dut (
        .clk              (clk),
        .rst              (rst),
        .flush            (flush),
        .in_valid         (in_valid),
        .in_pc            (in_pc),
        .in_op            (in_op),
        .in_src1          (in_src1),
        .in_src2          (in_src2),
        .in_mem_size      (in_mem_size),
        .in_gr_we         (in_gr_we),
        .in_res_from_mem  (in_res_from_mem),
        .in_mem_we        (in_mem_we),
        .in_waddr         (in_waddr),
        .counter          (counter),
        .mem_allowin      (mem_allowin),
        .allowin          (allowin),
        .out_valid        (out_valid),
        .out_pc           (out_pc),
        .out_result       (out_result),
        .out_waddr        (out_waddr),
        .out_gr_we        (out_gr_we),
        .out_res_from_mem (out_res_from_mem),
        .out_mem_we       (out_mem_we),
        .out_ale          (out_ale),
        .fwd_valid        (fwd_valid),
        .fwd_addr         (fwd_addr),
        .fwd_data         (fwd_data),
        .ex_is_load       (ex_is_load)
    );

    bind ex_stage ex_stage_assert u_sva (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .mem_allowin (mem_allowin),
        .allowin     (allowin),
        .out_valid   (out_valid),
        .held        (held),
        .readygo     (readygo),
        .waiting     (waiting),
        .out_pc      (out_pc),
        .out_result  (out_result),
        .out_waddr   (out_waddr),
        .out_ale     (out_ale)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    function automatic logic [31:0] case_pc(input int idx);
        return 32'h1c00_0000 + 32'(idx) * 32'd4;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic load_cases();
        integer      fd;
        integer      n;
        string       line;
        logic [31:0] v_fl;
        logic [31:0] v_op;
        logic [31:0] v_s1;
        logic [31:0] v_s2;
        logic [31:0] v_msz;
        logic [31:0] v_we;
        logic [31:0] v_ld;
        logic [31:0] v_st;
        logic [31:0] v_wa;
        logic [31:0] v_res;
        logic [31:0] v_ale;
        n_cases = 0;
        fd = $fopen("sim/ex_cases.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open sim/ex_cases.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", v_fl, v_op, v_s1,
                            v_s2, v_msz, v_we, v_ld, v_st, v_wa, v_res, v_ale);
                // comment lines match no field
                if (n == 11 && n_cases < max_cases) begin
                    c_flush[n_cases]  = v_fl[0];
                    c_op[n_cases]     = v_op[ex_pkg::op_w-1:0];
                    c_src1[n_cases]   = v_s1;
                    c_src2[n_cases]   = v_s2;
                    c_msz[n_cases]    = v_msz[1:0];
                    c_we[n_cases]     = v_we[0];
                    c_ld[n_cases]     = v_ld[0];
                    c_st[n_cases]     = v_st[0];
                    c_waddr[n_cases]  = v_wa[4:0];
                    c_result[n_cases] = v_res;
                    c_ale[n_cases]    = v_ale[0];
                    n_cases++;
                end
            end
            $fclose(fd);
        end
        if (n_cases == 0) begin
            errors++;
            $display("no cases were read from the case file");
        end
    endtask

    task automatic check_output();
        int          idx;
        logic [31:0] exp_res;
        logic        exp_fwd;
        n_out++;
        if (pend.size() == 0) begin
            errors++;
            $display("out_valid at %0t with no instruction in flight", $time);
        end else begin
            idx = pend.pop_front();
            if (c_op[idx] == ex_pkg::op_rdcntvl || c_op[idx] == ex_pkg::op_rdcntvh) begin
                exp_res = c_cnt[idx];
            end else begin
                exp_res = c_result[idx];
            end
            exp_fwd = c_we[idx] & ~c_ld[idx];
            check_value("out_pc", out_pc, case_pc(idx));
            check_value("out_result", out_result, exp_res);
            check_value("out_waddr", {27'b0, out_waddr}, {27'b0, c_waddr[idx]});
            check_value("out_gr_we", {31'b0, out_gr_we}, {31'b0, c_we[idx]});
            check_value("out_res_from_mem", {31'b0, out_res_from_mem}, {31'b0, c_ld[idx]});
            check_value("out_mem_we", {31'b0, out_mem_we}, {31'b0, c_st[idx]});
            check_value("out_ale", {31'b0, out_ale}, {31'b0, c_ale[idx]});
            check_value("fwd_valid", {31'b0, fwd_valid}, {31'b0, exp_fwd});
            check_value("ex_is_load", {31'b0, ex_is_load}, {31'b0, c_ld[idx]});
            if (exp_fwd) begin
                check_value("fwd_addr", {27'b0, fwd_addr}, {27'b0, c_waddr[idx]});
                check_value("fwd_data", fwd_data, exp_res);
            end
        end
    endtask

    // drive on the falling edge and sample just before the rising edge
    task automatic run_cycle(input int idx, input logic do_flush, output logic taken);
        @(negedge clk);
        counter     = counter + 64'd1;
        mem_allowin = (($random(seed) & 32'sd3) != 0);
        flush       = do_flush;
        if (idx >= 0) begin
            in_valid        = 1'b1;
            in_pc           = case_pc(idx);
            in_op           = c_op[idx];
            in_src1         = c_src1[idx];
            in_src2         = c_src2[idx];
            in_mem_size     = c_msz[idx];
            in_gr_we        = c_we[idx];
            in_res_from_mem = c_ld[idx];
            in_mem_we       = c_st[idx];
            in_waddr        = c_waddr[idx];
        end else begin
            in_valid = 1'b0;
        end
        #3;
        if (out_valid) begin
            check_output();
        end
        if (ex_is_load) begin
            check_value("fwd_valid", {31'b0, fwd_valid}, 32'd0);
        end
        taken = in_valid & allowin & ~flush;
    endtask

    task automatic flush_divide();
        logic taken;
        repeat (flush_delay) begin
            run_cycle(-1, 1'b0, taken);
        end
        run_cycle(-1, 1'b1, taken);
    endtask

    task automatic send_case(input int idx);
        logic taken;
        int   waited;
        taken  = 1'b0;
        waited = 0;
        while (!taken && !timed_out) begin
            run_cycle(idx, 1'b0, taken);
            waited++;
            if (!taken && waited >= send_limit) begin
                timed_out = 1'b1;
                errors++;
                $display("timeout: case %0d not accepted within %0d cycles", idx, send_limit);
            end
        end
        if (taken) begin
            // counter word on the accepting edge
            c_cnt[idx] = (c_op[idx] == ex_pkg::op_rdcntvh) ? counter[63:32] : counter[31:0];
            if (c_flush[idx]) begin
                flush_divide();
            end else begin
                pend.push_back(idx);
                n_expect++;
            end
        end
    endtask

    task automatic drain();
        logic taken;
        int   waited;
        waited = 0;
        while (pend.size() != 0 && !timed_out) begin
            run_cycle(-1, 1'b0, taken);
            waited++;
            if (pend.size() != 0 && waited >= drain_limit) begin
                timed_out = 1'b1;
                errors++;
                $display("timeout: %0d results still missing after %0d cycles",
                         pend.size(), drain_limit);
            end
        end
        // idle cycles catch a duplicated result
        repeat (8) begin
            run_cycle(-1, 1'b0, taken);
        end
    endtask

    initial begin
        seed            = 32'ha733_caa6;
        rst             = 1'b1;
        flush           = 1'b0;
        in_valid        = 1'b0;
        in_pc           = '0;
        in_op           = '0;
        in_src1         = '0;
        in_src2         = '0;
        in_mem_size     = '0;
        in_gr_we        = 1'b0;
        in_res_from_mem = 1'b0;
        in_mem_we       = 1'b0;
        in_waddr        = '0;
        counter         = 64'h0000_0001_ffff_fff0;
        mem_allowin     = 1'b1;
        checks          = 0;
        errors          = 0;
        n_out           = 0;
        n_expect        = 0;
        timed_out       = 1'b0;
        load_cases();
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #3;
        check_value("allowin", {31'b0, allowin}, 32'd1);
        check_value("out_valid", {31'b0, out_valid}, 32'd0);
        check_value("fwd_valid", {31'b0, fwd_valid}, 32'd0);
        check_value("ex_is_load", {31'b0, ex_is_load}, 32'd0);
        for (int i = 0; i < n_cases && !timed_out; i++) begin
            send_case(i);
        end
        if (!timed_out) begin
            drain();
        end
        check_value("output count", n_out, n_expect);
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, u_dut.u_sva.fail_count);
        if (errors == 0 && u_dut.u_sva.fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- sim/ex_cases.txt
# fl op src1 src2 msz gr_we ld st waddr result ale, all fields hex
# fl=1 flushes the divide; counter reads take the result from the counter
0 00 00000005 00000007 0 1 0 0 01 0000000c 0
0 00 ffffffff 00000001 0 1 0 0 02 00000000 0
0 01 00000003 00000005 0 1 0 0 03 fffffffe 0
0 02 ffffffff 00000001 0 1 0 0 04 00000001 0
0 03 ffffffff 00000001 0 1 0 0 05 00000000 0
0 04 f0f0f0f0 0ff00ff0 0 1 0 0 06 00f000f0 0
0 05 f0f0f0f0 0ff00ff0 0 1 0 0 07 fff0fff0 0
0 06 12345678 0000ffff 0 1 0 0 08 edcb0000 0
0 07 aaaaaaaa ffff0000 0 0 0 0 09 5555aaaa 0
0 08 00000001 0000001f 0 1 0 0 0a 80000000 0
0 08 00000003 00000021 0 1 0 0 0b 00000006 0
0 09 80000000 0000003f 0 1 0 0 0c 00000001 0
0 0a 80000000 00000004 0 1 0 0 0d f8000000 0
0 0a 7ffffff0 00000024 0 1 0 0 0e 07ffffff 0
0 0b 00000000 12345000 0 1 0 0 0f 12345000 0
0 0c 00000007 fffffffd 0 1 0 0 10 ffffffeb 0
0 0c 12345678 00000010 0 1 0 0 11 23456780 0
0 0d ffffffff ffffffff 0 1 0 0 12 00000000 0
0 0d 80000000 80000000 0 1 0 0 13 40000000 0
0 0d fffffffe 00000003 0 1 0 0 14 ffffffff 0
0 0e ffffffff ffffffff 0 1 0 0 15 fffffffe 0
0 0f 00000064 00000007 0 1 0 0 16 0000000e 0
0 10 00000064 00000007 0 1 0 0 17 00000002 0
0 0f fffffff9 00000002 0 1 0 0 18 fffffffd 0
0 10 fffffff9 00000002 0 1 0 0 19 ffffffff 0
0 0f 00000007 fffffffe 0 1 0 0 1a fffffffd 0
0 10 00000007 fffffffe 0 1 0 0 1b 00000001 0
0 11 ffffffff 00000010 0 1 0 0 1c 0fffffff 0
0 12 ffffffff 00000010 0 1 0 0 1d 0000000f 0
0 0f 12345678 00000000 0 1 0 0 1e ffffffff 0
0 10 12345678 00000000 0 1 0 0 1f 12345678 0
0 11 87654321 00000000 0 1 0 0 01 ffffffff 0
0 12 80000001 00000000 0 1 0 0 02 80000001 0
0 0f 80000000 ffffffff 0 1 0 0 03 80000000 0
0 10 80000000 ffffffff 0 1 0 0 04 00000000 0
1 0f 00000064 00000005 0 1 0 0 05 00000014 0
0 00 00000011 00000022 0 1 0 0 06 00000033 0
0 13 00000000 00000000 0 1 0 0 07 00000000 0
0 14 00000000 00000000 0 1 0 0 08 00000000 0
0 00 00001000 00000004 3 1 1 0 09 00001004 0
0 00 00001000 00000002 3 1 1 0 0a 00001002 1
0 00 00002001 00000000 2 1 1 0 0b 00002001 1
0 00 00002000 00000002 2 1 1 0 0c 00002002 0
0 00 00003000 00000003 1 0 0 1 00 00003003 0
0 00 00003000 fffffffc 3 0 0 1 00 00002ffc 0
0 00 00003000 00000005 2 0 0 1 00 00003005 1
0 00 00003001 00000001 3 1 1 0 0d 00003002 1
0 01 00000010 00000001 0 1 0 0 0e 0000000f 0

//--- flist.f
src/ex_pkg.sv
src/ex_alu.sv
src/ex_div_prep.sv
src/ex_div_step.sv
src/ex_div_post.sv
src/ex_stage.sv
sim/ex_stage_assert.sv
sim/ex_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the ex_stage testbench with Verilator
set -e

cd "$(dirname "$0")"
mkdir -p build

verilator --binary --timing --assert -Wno-fatal \
    --top-module ex_stage_tb -f flist.f \
    --Mdir build/obj_dir -o ex_stage_sim

# the log decides pass or fail, not the exit status
./build/obj_dir/ex_stage_sim +verilator+error+limit+1000 > build/sim.log 2>&1 || true
cat build/sim.log

if grep -q -F '*** PASSED ***' build/sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
